// File: bench/mmio_bridge_assert.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_bridge_assert
	import mmio_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire cmd_valid,
	input wire cmd_t cmd_data,
	input wire cmd_ready,
	input wire rsp_valid,
	input wire rsp_ready,
	input wire cpl_valid,
	input wire tid_push,
	input wire tid_pop
);

	// tids currently held by the queue
	tid_ptr_t outstanding;

	always_ff @(posedge clk) begin
		if (rst) begin
			outstanding <= '0;
		end else begin
			outstanding <= outstanding + tid_ptr_t'(tid_push) - tid_ptr_t'(tid_pop);
		end
	end

	a_cmd_hold: assert property (@(posedge clk) disable iff (rst)
		cmd_valid && !cmd_ready |=> cmd_valid && $stable(cmd_data))
		else $error("command slot changed before its handshake");

	a_push_not_full: assert property (@(posedge clk) disable iff (rst)
		tid_push |-> outstanding != tid_ptr_t'(TID_FIFO_DEPTH))
		else $error("tid pushed into a full queue");

	a_pop_not_empty: assert property (@(posedge clk) disable iff (rst)
		tid_pop |-> outstanding != '0)
		else $error("tid popped from an empty queue");

	// completion exactly one cycle after the response handshake
	a_cpl_after_rsp: assert property (@(posedge clk) disable iff (rst)
		rsp_valid && rsp_ready |=> cpl_valid)
		else $error("response handshake gave no completion");

	a_cpl_has_rsp: assert property (@(posedge clk) disable iff (rst)
		cpl_valid |-> $past(rsp_valid && rsp_ready))
		else $error("completion without a response handshake");

endmodule

bind mmio_to_avst mmio_bridge_assert u_mmio_bridge_assert (
	.clk(clk),
	.rst(rst),
	.cmd_valid(cmd_valid),
	.cmd_data(cmd_data),
	.cmd_ready(cmd_ready),
	.rsp_valid(rsp_valid),
	.rsp_ready(rsp_ready),
	.cpl_valid(cpl_valid),
	.tid_push(tid_push),
	.tid_pop(tid_pop)
);

`default_nettype wire

// File: bench/mmio_bridge_tb.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_bridge_tb
	import mmio_pkg::*;
();

	localparam int CLK_PERIOD = 20;
	localparam int CPL_TIMEOUT = 50;
	localparam int QUIET_CYCLES = 12;

	logic clk = 1'b0;
	logic rst;

	logic wr_req_valid;
	logic rd_req_valid;
	mmio_addr_t req_addr;
	tid_t req_tid;
	mmio_data_t req_data;

	logic cpl_valid;
	tid_t cpl_tid;
	mmio_data_t cpl_data;
	logic cmd_overflow;

	// stimulus table, one entry per row
	bit row_is_read [$];
	mmio_addr_t row_addr [$];
	tid_t row_tid [$];
	mmio_data_t row_wdata [$];
	mmio_data_t row_expected [$];
	int read_rows [$];

	// reference copy of the register file
	mmio_data_t model [REG_COUNT];

	integer seed;
	int fail_count;
	int cpl_count;

	mmio_bridge_top u_mmio_bridge_top (
		.clk(clk),
		.rst(rst),
		.wr_req_valid(wr_req_valid),
		.rd_req_valid(rd_req_valid),
		.req_addr(req_addr),
		.req_tid(req_tid),
		.req_data(req_data),
		.cpl_valid(cpl_valid),
		.cpl_tid(cpl_tid),
		.cpl_data(cpl_data),
		.cmd_overflow(cmd_overflow)
	);

	always begin
		#(CLK_PERIOD / 2) clk = ~clk;
	end

	task automatic abort_run(input string reason);
		$display("%s", reason);
		$display("Test failed");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input string what, input logic [63:0] actual,
		input logic [63:0] expected);
		if (actual !== expected) begin
			fail_count++;
			$display("Mismatch at %0t: %s is %h, expected %h",
				$time, what, actual, expected);
			abort_run("stopping at the first mismatch");
		end
	endtask

	// byte address bits above 6 are dword address bits above 4
	function automatic logic addr_mapped(input mmio_addr_t addr);
		return (addr[MMIO_ADDR_WIDTH-1:5] == '0);
	endfunction

	// byte address bits 6 to 3 are dword address bits 4 to 1
	function automatic reg_idx_t addr_index(input mmio_addr_t addr);
		return addr[4:1];
	endfunction

	task automatic add_row(input bit is_read, input mmio_addr_t addr);
		int row;
		reg_idx_t idx;
		mmio_data_t wdata;
		mmio_data_t expected;
		row = row_addr.size();
		idx = addr_index(addr);
		wdata = '0;
		expected = '0;
		if (is_read) begin
			if (!addr_mapped(addr)) begin
				expected = '1;
			end else if (idx == '0) begin
				expected = DEVICE_ID;
			end else begin
				expected = model[idx];
			end
			read_rows.push_back(row);
		end else begin
			wdata = {$random(seed), $random(seed)};
			// entry 0 and unmapped addresses ignore writes
			if (addr_mapped(addr) && idx != '0) begin
				model[idx] = wdata;
			end
		end
		row_is_read.push_back(is_read);
		row_addr.push_back(addr);
		row_tid.push_back(tid_t'(row * 5 + 1));
		row_wdata.push_back(wdata);
		row_expected.push_back(expected);
	endtask

	task automatic build_table();
		int i;
		for (i = 0; i < REG_COUNT; i++) begin
			model[i] = '0;
		end
		add_row(1'b1, 16'h0000);
		for (i = 1; i < REG_COUNT; i++) begin
			add_row(1'b0, mmio_addr_t'(2 * i));
		end
		for (i = 1; i < REG_COUNT; i++) begin
			add_row(1'b1, mmio_addr_t'(2 * i));
		end
		// outside the map
		add_row(1'b1, 16'h0100);
		add_row(1'b1, 16'h8000);
		// same index bits as entry 1, but unmapped
		add_row(1'b0, 16'h0102);
		add_row(1'b1, 16'h0002);
		// device ID is read only
		add_row(1'b0, 16'h0000);
		add_row(1'b1, 16'h0000);
		add_row(1'b1, 16'h001e);
	endtask

	// one row per cycle, no gaps
	task automatic drive_table();
		int r;
		for (r = 0; r < row_addr.size(); r++) begin
			@(negedge clk);
			check_value("cmd_overflow", 64'(cmd_overflow), 64'd0);
			wr_req_valid = !row_is_read[r];
			rd_req_valid = row_is_read[r];
			req_addr = row_addr[r];
			req_tid = row_tid[r];
			req_data = row_wdata[r];
		end
		@(negedge clk);
		wr_req_valid = 1'b0;
		rd_req_valid = 1'b0;
	endtask

	task automatic collect_completions();
		int k;
		int waited;
		int row;
		for (k = 0; k < read_rows.size(); k++) begin
			row = read_rows[k];
			waited = 0;
			@(negedge clk);
			while (!cpl_valid) begin
				waited++;
				if (waited > CPL_TIMEOUT) begin
					abort_run($sformatf("timed out waiting for the completion of read %0d", k));
				end
				@(negedge clk);
			end
			cpl_count++;
			check_value($sformatf("tid of read %0d", k), 64'(cpl_tid), 64'(row_tid[row]));
			check_value($sformatf("data of read %0d", k), cpl_data, row_expected[row]);
		end
		// any completion after the last read is an extra one
		for (waited = 0; waited < QUIET_CYCLES; waited++) begin
			@(negedge clk);
			if (cpl_valid) begin
				cpl_count++;
			end
		end
	endtask

	initial begin
		seed = 32'h2aad;
		fail_count = 0;
		cpl_count = 0;
		rst = 1'b1;
		wr_req_valid = 1'b0;
		rd_req_valid = 1'b0;
		req_addr = '0;
		req_tid = '0;
		req_data = '0;

		build_table();

		repeat (3) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;

		fork
			drive_table();
			collect_completions();
		join

		check_value("completion count", 64'(cpl_count), 64'(read_rows.size()));
		check_value("cmd_overflow at end", 64'(cmd_overflow), 64'd0);

		if (fail_count == 0) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: mmio_bridge.f
src/mmio_pkg.sv
src/tid_fifo.sv
src/mmio_to_avst.sv
src/avmm_reg_block.sv
src/mmio_bridge_top.sv
bench/mmio_bridge_assert.sv
bench/mmio_bridge_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds and runs the MMIO bridge testbench with Verilator.
# Exits nonzero unless the log holds the pass message.
set -u

cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -rf obj_dir
rm -f "$LOG"

verilator --binary --timing --assert -j 0 \
	--top-module mmio_bridge_tb -f mmio_bridge.f -o mmio_bridge_sim > "$LOG" 2>&1 \
	&& ./obj_dir/mmio_bridge_sim >> "$LOG" 2>&1 \
	|| echo "build or simulation returned an error" >> "$LOG"

grep -q "Test completed successfully" "$LOG" && echo "PASS (see $LOG)" && exit 0
echo "FAIL (see $LOG)"
exit 1

// File: src/avmm_reg_block.sv
`timescale 1ns/1ps
`default_nettype none

module avmm_reg_block
	import mmio_pkg::*;
(
	input wire clk,
	input wire rst,

	input wire cmd_valid,
	input wire cmd_t cmd_data,
	output logic cmd_ready,

	output logic rsp_valid,
	output mmio_data_t rsp_data,
	input wire rsp_ready
);

	logic is_read;
	avmm_addr_t cmd_addr;
	mmio_data_t cmd_wdata;
	reg_idx_t cmd_idx;
	logic mapped;
	logic cmd_fire;
	logic scratch_wr;

	// entry 0 is the device ID, not stored
	mmio_data_t scratch [1:REG_COUNT-1];

	logic s1_valid;
	reg_idx_t s1_idx;
	logic s1_mapped;
	mmio_data_t s1_rdata;
	logic s2_valid;
	mmio_data_t s2_data;
	logic s1_advance;
	logic s2_advance;

	// command fields
	assign is_read = cmd_data[CMD_READ_BIT];
	assign cmd_addr = cmd_data[CMD_ADDR_LSB +: AVMM_ADDR_WIDTH];
	assign cmd_wdata = cmd_data[DATA_WIDTH-1:0];
	assign cmd_idx = cmd_addr[REG_IDX_LSB +: REG_IDX_WIDTH];

	// any bit above the index field means outside the map
	assign mapped = (cmd_addr[AVMM_ADDR_WIDTH-1:REG_IDX_LSB+REG_IDX_WIDTH] == '0);

	// pipeline moves when the next stage is free or draining
	assign s2_advance = !s2_valid || rsp_ready;
	assign s1_advance = !s1_valid || s2_advance;
	assign cmd_ready = s1_advance;
	assign cmd_fire = cmd_valid && cmd_ready;

	assign scratch_wr = cmd_fire && !is_read && mapped &&
		(cmd_idx != reg_idx_t'(DEVICE_ID_IDX));

	always_ff @(posedge clk) begin
		if (rst) begin
			for (int i = 1; i < REG_COUNT; i++) begin
				scratch[i] <= '0;
			end
		end else if (scratch_wr) begin
			scratch[cmd_idx] <= cmd_wdata;
		end
	end

	// read data select for stage 1
	always_comb begin
		if (!s1_mapped) begin
			s1_rdata = UNMAPPED_DATA;
		end else if (s1_idx == reg_idx_t'(DEVICE_ID_IDX)) begin
			s1_rdata = DEVICE_ID;
		end else begin
			s1_rdata = scratch[s1_idx];
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			s1_valid <= 1'b0;
			s2_valid <= 1'b0;
		end else begin
			if (s1_advance) begin
				s1_valid <= cmd_fire && is_read;
			end
			if (s2_advance) begin
				s2_valid <= s1_valid;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (s1_advance) begin
			s1_idx <= cmd_idx;
			s1_mapped <= mapped;
		end
		if (s2_advance && s1_valid) begin
			s2_data <= s1_rdata;
		end
	end

	assign rsp_valid = s2_valid;
	assign rsp_data = s2_data;

endmodule

`default_nettype wire

// File: src/mmio_bridge_top.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_bridge_top
	import mmio_pkg::*;
(
	input wire clk,
	input wire rst,

	input wire wr_req_valid,
	input wire rd_req_valid,
	input wire mmio_addr_t req_addr,
	input wire tid_t req_tid,
	input wire mmio_data_t req_data,

	output logic cpl_valid,
	output tid_t cpl_tid,
	output mmio_data_t cpl_data,
	output logic cmd_overflow
);

	// command stream
	logic cmd_valid;
	cmd_t cmd_data;
	logic cmd_ready;

	// response stream
	logic rsp_valid;
	mmio_data_t rsp_data;
	logic rsp_ready;

	// tid queue
	logic tid_push;
	tid_t push_tid;
	logic tid_pop;
	tid_t head_tid;
	logic empty;

	mmio_to_avst u_mmio_to_avst (
		.clk(clk),
		.rst(rst),
		.wr_req_valid(wr_req_valid),
		.rd_req_valid(rd_req_valid),
		.req_addr(req_addr),
		.req_tid(req_tid),
		.req_data(req_data),
		.cmd_valid(cmd_valid),
		.cmd_data(cmd_data),
		.cmd_ready(cmd_ready),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.rsp_ready(rsp_ready),
		.cpl_valid(cpl_valid),
		.cpl_tid(cpl_tid),
		.cpl_data(cpl_data),
		.cmd_overflow(cmd_overflow),
		.tid_push(tid_push),
		.push_tid(push_tid),
		.tid_pop(tid_pop),
		.head_tid(head_tid),
		.empty(empty)
	);

	tid_fifo u_tid_fifo (
		.clk(clk),
		.rst(rst),
		.tid_push(tid_push),
		.push_tid(push_tid),
		.tid_pop(tid_pop),
		.head_tid(head_tid),
		.empty(empty)
	);

	avmm_reg_block u_avmm_reg_block (
		.clk(clk),
		.rst(rst),
		.cmd_valid(cmd_valid),
		.cmd_data(cmd_data),
		.cmd_ready(cmd_ready),
		.rsp_valid(rsp_valid),
		.rsp_data(rsp_data),
		.rsp_ready(rsp_ready)
	);

endmodule

`default_nettype wire

// File: src/mmio_pkg.sv
`default_nettype none

package mmio_pkg;

	// host request fields
	localparam int MMIO_ADDR_WIDTH = 16;
	localparam int AVMM_ADDR_WIDTH = 18;
	localparam int DATA_WIDTH = 64;
	localparam int TID_WIDTH = 9;

	// outstanding read queue
	localparam int TID_FIFO_DEPTH = 64;
	localparam int TID_PTR_WIDTH = $clog2(TID_FIFO_DEPTH);

	// command word is {read flag, byte address, write data}
	localparam int CMD_WIDTH = 1 + AVMM_ADDR_WIDTH + DATA_WIDTH;
	localparam int CMD_READ_BIT = CMD_WIDTH - 1;
	localparam int CMD_ADDR_LSB = DATA_WIDTH;

	// register map, one 64-bit entry per 8 bytes
	localparam int REG_COUNT = 16;
	localparam int REG_IDX_WIDTH = $clog2(REG_COUNT);
	localparam int REG_IDX_LSB = 3;
	localparam int DEVICE_ID_IDX = 0;

	typedef logic [MMIO_ADDR_WIDTH-1:0] mmio_addr_t;
	typedef logic [AVMM_ADDR_WIDTH-1:0] avmm_addr_t;
	typedef logic [DATA_WIDTH-1:0] mmio_data_t;
	typedef logic [TID_WIDTH-1:0] tid_t;
	typedef logic [CMD_WIDTH-1:0] cmd_t;
	typedef logic [REG_IDX_WIDTH-1:0] reg_idx_t;
	// extra msb tells full from empty
	typedef logic [TID_PTR_WIDTH:0] tid_ptr_t;

	// entry 0 contents, "MMIO" plus a revision
	localparam mmio_data_t DEVICE_ID = 64'h4d4d_494f_0001_0000;
	localparam mmio_data_t UNMAPPED_DATA = '1;

endpackage

`default_nettype wire

// File: src/mmio_to_avst.sv
`timescale 1ns/1ps
`default_nettype none

module mmio_to_avst
	import mmio_pkg::*;
(
	input wire clk,
	input wire rst,

	// host requests, cannot be stalled
	input wire wr_req_valid,
	input wire rd_req_valid,
	input wire mmio_addr_t req_addr,
	input wire tid_t req_tid,
	input wire mmio_data_t req_data,

	// command stream
	output logic cmd_valid,
	output cmd_t cmd_data,
	input wire cmd_ready,

	// response stream
	input wire rsp_valid,
	input wire mmio_data_t rsp_data,
	output logic rsp_ready,

	// host completions
	output logic cpl_valid,
	output tid_t cpl_tid,
	output mmio_data_t cpl_data,
	output logic cmd_overflow,

	// tid queue
	output logic tid_push,
	output tid_t push_tid,
	output logic tid_pop,
	input wire tid_t head_tid,
	input wire empty
);

	logic req_wr_q;
	logic req_rd_q;
	mmio_addr_t req_addr_q;
	tid_t req_tid_q;
	mmio_data_t req_data_q;

	logic req_pending;
	logic slot_free;
	logic slot_load;
	logic req_drop;
	logic rsp_fire;

	assign req_pending = req_wr_q || req_rd_q;

	// slot takes a new command when empty or draining this cycle
	assign slot_free = !cmd_valid || cmd_ready;
	assign slot_load = req_pending && slot_free;
	assign req_drop = req_pending && !slot_free;

	// only reads that reach the slot queue a tid
	assign tid_push = req_rd_q && slot_load;
	assign push_tid = req_tid_q;

	// never take a response without a tid to pair it with
	assign rsp_ready = !empty;
	assign rsp_fire = rsp_valid && rsp_ready;
	assign tid_pop = rsp_fire;

	// host request capture
	always_ff @(posedge clk) begin
		if (rst) begin
			req_wr_q <= 1'b0;
			req_rd_q <= 1'b0;
		end else begin
			req_wr_q <= wr_req_valid;
			req_rd_q <= rd_req_valid;
		end
	end

	always_ff @(posedge clk) begin
		req_addr_q <= req_addr;
		req_tid_q <= req_tid;
		req_data_q <= req_data;
	end

	// one-entry command slot
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd_valid <= 1'b0;
		end else if (slot_load) begin
			cmd_valid <= 1'b1;
		end else if (cmd_ready) begin
			cmd_valid <= 1'b0;
		end
	end

	// dword address becomes a byte address
	always_ff @(posedge clk) begin
		if (slot_load) begin
			cmd_data <= {req_rd_q, avmm_addr_t'({req_addr_q, 2'b00}), req_data_q};
		end
	end

	// sticky until reset
	always_ff @(posedge clk) begin
		if (rst) begin
			cmd_overflow <= 1'b0;
		end else if (req_drop) begin
			cmd_overflow <= 1'b1;
		end
	end

	// completion, one cycle after the response handshake
	always_ff @(posedge clk) begin
		if (rst) begin
			cpl_valid <= 1'b0;
		end else begin
			cpl_valid <= rsp_fire;
		end
	end

	always_ff @(posedge clk) begin
		if (rsp_fire) begin
			cpl_tid <= head_tid;
			cpl_data <= rsp_data;
		end
	end

endmodule

`default_nettype wire

// File: src/tid_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module tid_fifo
	import mmio_pkg::*;
(
	input wire clk,
	input wire rst,
	input wire tid_push,
	input wire tid_t push_tid,
	input wire tid_pop,
	output tid_t head_tid,
	output logic empty
);

	tid_t mem [TID_FIFO_DEPTH];
	tid_ptr_t wr_ptr;
	tid_ptr_t rd_ptr;
	logic full;
	logic do_push;
	logic do_pop;

	// same slot index, wrap bits differ when full
	assign empty = (wr_ptr == rd_ptr);
	assign full = (wr_ptr[TID_PTR_WIDTH] != rd_ptr[TID_PTR_WIDTH]) &&
		(wr_ptr[TID_PTR_WIDTH-1:0] == rd_ptr[TID_PTR_WIDTH-1:0]);

	// overflow and underflow are ignored
	assign do_push = tid_push && !full;
	assign do_pop = tid_pop && !empty;

	// show-ahead head
	assign head_tid = mem[rd_ptr[TID_PTR_WIDTH-1:0]];

	always_ff @(posedge clk) begin
		if (rst) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (do_push) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (do_pop) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (do_push) begin
			mem[wr_ptr[TID_PTR_WIDTH-1:0]] <= push_tid;
		end
	end

endmodule

`default_nettype wire
